/* rtl/biu_settings.svh */
`ifndef BIU_SETTINGS_SVH
`define BIU_SETTINGS_SVH

// Bus widths
`define BIU_ADDR_W     32
`define BIU_DATA_W     32
`define BIU_ID_W       4
`define BIU_LEN_W      8

// Words per instruction line fill
`define BIU_IFU_BEATS  4

// Largest LSU write burst the buffer holds
`define BIU_WR_DEPTH   4

// AXI IDs per requester
`define BIU_IFU_ID     0
`define BIU_LSU_ID     1

`endif

/* rtl/biu_pkg.sv */
`include "biu_settings.svh"

package biu_pkg;

   typedef logic [`BIU_ADDR_W-1:0]   addr_t;
   typedef logic [`BIU_DATA_W-1:0]   data_t;
   typedef logic [`BIU_DATA_W/8-1:0] strb_t;
   typedef logic [`BIU_ID_W-1:0]     axi_id_t;
   typedef logic [`BIU_LEN_W-1:0]    axi_len_t;
   typedef logic [1:0]               axi_resp_t;

   // Shared by AR and AW
   typedef struct packed {
      axi_id_t  id;
      addr_t    addr;
      axi_len_t len;
   } axi_a_t;

   typedef struct packed {
      data_t data;
      strb_t strb;
      logic  last;
   } axi_w_t;

   typedef struct packed {
      axi_id_t   id;
      data_t     data;
      axi_resp_t resp;
      logic      last;
   } axi_r_t;

   typedef struct packed {
      axi_id_t   id;
      axi_resp_t resp;
   } axi_b_t;

   typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;

   typedef enum logic [1:0] {WR_FILL, WR_ADDR, WR_DATA, WR_RESP} wr_state_e;

endpackage

/* rtl/biu_rd_arb.sv */
`include "biu_settings.svh"

module biu_rd_arb (
   input  logic            clk,
   input  logic            reset,

   input  logic            ifu_rd_req,
   input  biu_pkg::addr_t  ifu_rd_addr,
   input  logic            lsu_rd_req,
   input  biu_pkg::addr_t  lsu_rd_addr,

   input  logic            rd_free,
   input  logic            rd_issued,

   output logic            ifu_rd_ack,
   output logic            lsu_rd_ack,
   output logic            rd_pending,
   output biu_pkg::axi_a_t rd_beat
);

   // High when the IFU won the previous grant
   logic last_ifu;
   logic grant;
   logic pick_ifu;

   assign grant    = rd_free && (ifu_rd_req || lsu_rd_req);
   assign pick_ifu = ifu_rd_req && (!lsu_rd_req || !last_ifu);

   always_ff @(posedge clk) begin
      if (reset) begin
         ifu_rd_ack <= 1'b0;
         lsu_rd_ack <= 1'b0;
         rd_pending <= 1'b0;
         last_ifu   <= 1'b0;
      end else begin
         ifu_rd_ack <= grant && pick_ifu;
         lsu_rd_ack <= grant && !pick_ifu;
         if (grant) begin
            rd_pending <= 1'b1;
            last_ifu   <= pick_ifu;
         end else if (rd_issued) begin
            rd_pending <= 1'b0;
         end
      end
   end

   // Address beat held until the next grant
   always_ff @(posedge clk) begin
      if (grant) begin
         if (pick_ifu) begin
            rd_beat.id   <= biu_pkg::axi_id_t'(`BIU_IFU_ID);
            rd_beat.addr <= ifu_rd_addr;
            rd_beat.len  <= biu_pkg::axi_len_t'(`BIU_IFU_BEATS - 1);
         end else begin
            rd_beat.id   <= biu_pkg::axi_id_t'(`BIU_LSU_ID);
            rd_beat.addr <= lsu_rd_addr;
            rd_beat.len  <= '0;
         end
      end
   end

   // One requester acked at a time, and only with a read waiting to issue
   a_one_ack: assert property (@(posedge clk) disable iff (reset)
      (ifu_rd_ack || lsu_rd_ack) |-> !(ifu_rd_ack && lsu_rd_ack) && rd_pending);

endmodule

/* rtl/biu_wr_buf.sv */
`include "biu_settings.svh"

module biu_wr_buf (
   input  logic            clk,
   input  logic            reset,

   input  logic            lsu_wr_req,
   input  biu_pkg::addr_t  lsu_wr_addr,
   input  biu_pkg::data_t  lsu_wr_data,
   input  biu_pkg::strb_t  lsu_wr_strb,
   input  logic            lsu_wr_last,

   input  logic            fill_en,
   input  logic            w_pop,

   output logic            lsu_wr_ack,
   output logic            burst_done,
   output biu_pkg::axi_a_t wr_beat,
   output biu_pkg::axi_w_t w_beat
);

   localparam int PTR_W = $clog2(`BIU_WR_DEPTH);
   localparam int CNT_W = $clog2(`BIU_WR_DEPTH + 1);

   biu_pkg::data_t   data_mem [`BIU_WR_DEPTH];
   biu_pkg::strb_t   strb_mem [`BIU_WR_DEPTH];
   biu_pkg::addr_t   first_addr;
   logic [CNT_W-1:0] count;
   logic [PTR_W-1:0] rd_ptr;

   assign lsu_wr_ack = fill_en && lsu_wr_req && (count < CNT_W'(`BIU_WR_DEPTH));
   assign burst_done = lsu_wr_ack && lsu_wr_last;

   always_ff @(posedge clk) begin
      if (reset) begin
         count  <= '0;
         rd_ptr <= '0;
      end else if (lsu_wr_ack) begin
         count <= count + 1'b1;
      end else if (w_pop) begin
         if (w_beat.last) begin
            count  <= '0;
            rd_ptr <= '0;
         end else begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (lsu_wr_ack) begin
         data_mem[count[PTR_W-1:0]] <= lsu_wr_data;
         strb_mem[count[PTR_W-1:0]] <= lsu_wr_strb;
         // Burst address comes from the first beat
         if (count == '0) begin
            first_addr <= lsu_wr_addr;
         end
      end
   end

   assign wr_beat.id   = biu_pkg::axi_id_t'(`BIU_LSU_ID);
   assign wr_beat.addr = first_addr;
   assign wr_beat.len  = biu_pkg::axi_len_t'(count - 1'b1);

   assign w_beat.data = data_mem[rd_ptr];
   assign w_beat.strb = strb_mem[rd_ptr];
   assign w_beat.last = (CNT_W'(rd_ptr) + 1'b1) == count;

   // LSU burst must end with last before the buffer is full
   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      fill_en |-> count < CNT_W'(`BIU_WR_DEPTH));

endmodule

/* rtl/biu_rdata_route.sv */
`include "biu_settings.svh"

module biu_rdata_route (
   input  logic            clk,
   input  logic            reset,

   input  logic            r_fire,
   input  biu_pkg::axi_r_t r_beat,
   input  logic            ifu_cancel,
   input  logic            ifu_busy,

   output logic            ifu_data_valid,
   output logic            lsu_data_valid,
   output biu_pkg::data_t  rdata
);

   logic cancel_flag;
   logic is_ifu;
   logic is_lsu;
   logic drop_ifu;

   assign is_ifu   = r_beat.id == biu_pkg::axi_id_t'(`BIU_IFU_ID);
   assign is_lsu   = r_beat.id == biu_pkg::axi_id_t'(`BIU_LSU_ID);
   // A cancel in the same cycle already drops the beat
   assign drop_ifu = cancel_flag || (ifu_cancel && ifu_busy);

   always_ff @(posedge clk) begin
      if (reset) begin
         cancel_flag <= 1'b0;
      end else if (!ifu_busy) begin
         cancel_flag <= 1'b0;
      end else if (ifu_cancel) begin
         cancel_flag <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ifu_data_valid <= 1'b0;
         lsu_data_valid <= 1'b0;
      end else begin
         ifu_data_valid <= r_fire && is_ifu && !drop_ifu;
         lsu_data_valid <= r_fire && is_lsu;
      end
   end

   always_ff @(posedge clk) begin
      if (r_fire) begin
         rdata <= r_beat.data;
      end
   end

endmodule

/* rtl/biu_axi_ctrl.sv */
`include "biu_settings.svh"

module biu_axi_ctrl (
   input  logic            clk,
   input  logic            reset,

   // Read side
   input  logic            rd_pending,
   input  biu_pkg::axi_a_t rd_beat,
   output logic            rd_free,
   output logic            rd_issued,
   output logic            ifu_busy,

   input  logic            ar_ready,
   output logic            ar_valid,
   output biu_pkg::axi_a_t ar_beat,

   input  logic            r_valid,
   input  biu_pkg::axi_r_t r_beat,
   output logic            r_ready,
   output logic            r_fire,

   // Write side
   input  logic            burst_done,
   input  biu_pkg::axi_a_t wr_beat,
   input  biu_pkg::axi_w_t w_beat,
   output logic            fill_en,
   output logic            w_pop,

   input  logic            aw_ready,
   output logic            aw_valid,
   output biu_pkg::axi_a_t aw_beat,

   input  logic            w_ready,
   output logic            w_valid,
   output biu_pkg::axi_w_t w_out,

   input  logic            b_valid,
   input  biu_pkg::axi_b_t b_beat,
   output logic            b_ready
);

   biu_pkg::rd_state_e rd_state;
   biu_pkg::rd_state_e rd_next;
   biu_pkg::wr_state_e wr_state;
   biu_pkg::wr_state_e wr_next;
   logic               b_done;

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_state <= biu_pkg::RD_IDLE;
         wr_state <= biu_pkg::WR_FILL;
      end else begin
         rd_state <= rd_next;
         wr_state <= wr_next;
      end
   end

   always_comb begin
      rd_next = rd_state;
      case (rd_state)
         biu_pkg::RD_IDLE: begin
            if (rd_pending) begin
               rd_next = biu_pkg::RD_ADDR;
            end
         end
         biu_pkg::RD_ADDR: begin
            if (ar_ready) begin
               rd_next = biu_pkg::RD_DATA;
            end
         end
         biu_pkg::RD_DATA: begin
            if (r_fire && r_beat.last) begin
               rd_next = biu_pkg::RD_IDLE;
            end
         end
         default: rd_next = biu_pkg::RD_IDLE;
      endcase
   end

   // Nothing granted until the previous read has fully drained
   assign rd_free   = (rd_state == biu_pkg::RD_IDLE) && !rd_pending;
   assign ar_valid  = rd_state == biu_pkg::RD_ADDR;
   assign ar_beat   = rd_beat;
   assign rd_issued = ar_valid && ar_ready;
   assign r_ready   = rd_state == biu_pkg::RD_DATA;
   assign r_fire    = r_valid && r_ready;

   // Covers the window from ack to the last beat
   assign ifu_busy = (rd_beat.id == biu_pkg::axi_id_t'(`BIU_IFU_ID))
                     && (rd_pending || rd_state != biu_pkg::RD_IDLE);

   always_comb begin
      wr_next = wr_state;
      case (wr_state)
         biu_pkg::WR_FILL: begin
            if (burst_done) begin
               wr_next = biu_pkg::WR_ADDR;
            end
         end
         biu_pkg::WR_ADDR: begin
            if (aw_ready) begin
               wr_next = biu_pkg::WR_DATA;
            end
         end
         biu_pkg::WR_DATA: begin
            if (w_pop && w_beat.last) begin
               wr_next = biu_pkg::WR_RESP;
            end
         end
         biu_pkg::WR_RESP: begin
            if (b_done) begin
               wr_next = biu_pkg::WR_FILL;
            end
         end
         default: wr_next = biu_pkg::WR_FILL;
      endcase
   end

   assign fill_en  = wr_state == biu_pkg::WR_FILL;
   assign aw_valid = wr_state == biu_pkg::WR_ADDR;
   assign aw_beat  = wr_beat;
   assign w_valid  = wr_state == biu_pkg::WR_DATA;
   assign w_out    = w_beat;
   assign w_pop    = w_valid && w_ready;
   assign b_ready  = wr_state == biu_pkg::WR_RESP;
   // Only the LSU writes, so only its ID closes a burst
   assign b_done   = b_valid && b_ready && (b_beat.id == biu_pkg::axi_id_t'(`BIU_LSU_ID));

   a_ar_stable: assert property (@(posedge clk) disable iff (reset)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar_beat));

   a_r_last_in_data: assert property (@(posedge clk) disable iff (reset)
      r_valid && r_beat.last |-> rd_state == biu_pkg::RD_DATA);

endmodule

/* rtl/biu_top.sv */
module biu_top (
   input  logic            clk,
   input  logic            reset,

   // IFU
   input  logic            ifu_rd_req,
   input  biu_pkg::addr_t  ifu_rd_addr,
   input  logic            ifu_cancel,
   output logic            ifu_rd_ack,
   output logic            ifu_data_valid,
   output biu_pkg::data_t  ifu_data,

   // LSU reads
   input  logic            lsu_rd_req,
   input  biu_pkg::addr_t  lsu_rd_addr,
   output logic            lsu_rd_ack,
   output logic            lsu_data_valid,
   output biu_pkg::data_t  lsu_data,

   // LSU writes
   input  logic            lsu_wr_req,
   input  biu_pkg::addr_t  lsu_wr_addr,
   input  biu_pkg::data_t  lsu_wr_data,
   input  biu_pkg::strb_t  lsu_wr_strb,
   input  logic            lsu_wr_last,
   output logic            lsu_wr_ack,

   // AXI manager
   output logic            ar_valid,
   input  logic            ar_ready,
   output biu_pkg::axi_a_t ar_beat,
   input  logic            r_valid,
   output logic            r_ready,
   input  biu_pkg::axi_r_t r_beat,
   output logic            aw_valid,
   input  logic            aw_ready,
   output biu_pkg::axi_a_t aw_beat,
   output logic            w_valid,
   input  logic            w_ready,
   output biu_pkg::axi_w_t w_beat,
   input  logic            b_valid,
   output logic            b_ready,
   input  biu_pkg::axi_b_t b_beat
);

   logic            rd_free;
   logic            rd_issued;
   logic            rd_pending;
   biu_pkg::axi_a_t rd_beat;
   logic            r_fire;
   logic            ifu_busy;
   logic            fill_en;
   logic            w_pop;
   logic            burst_done;
   biu_pkg::axi_a_t wr_beat;
   biu_pkg::axi_w_t buf_w_beat;
   biu_pkg::data_t  rdata;

   biu_rd_arb u_rd_arb (
      .clk         (clk),
      .reset       (reset),
      .ifu_rd_req  (ifu_rd_req),
      .ifu_rd_addr (ifu_rd_addr),
      .lsu_rd_req  (lsu_rd_req),
      .lsu_rd_addr (lsu_rd_addr),
      .rd_free     (rd_free),
      .rd_issued   (rd_issued),
      .ifu_rd_ack  (ifu_rd_ack),
      .lsu_rd_ack  (lsu_rd_ack),
      .rd_pending  (rd_pending),
      .rd_beat     (rd_beat)
   );

   biu_wr_buf u_wr_buf (
      .clk         (clk),
      .reset       (reset),
      .lsu_wr_req  (lsu_wr_req),
      .lsu_wr_addr (lsu_wr_addr),
      .lsu_wr_data (lsu_wr_data),
      .lsu_wr_strb (lsu_wr_strb),
      .lsu_wr_last (lsu_wr_last),
      .fill_en     (fill_en),
      .w_pop       (w_pop),
      .lsu_wr_ack  (lsu_wr_ack),
      .burst_done  (burst_done),
      .wr_beat     (wr_beat),
      .w_beat      (buf_w_beat)
   );

   biu_rdata_route u_rdata_route (
      .clk            (clk),
      .reset          (reset),
      .r_fire         (r_fire),
      .r_beat         (r_beat),
      .ifu_cancel     (ifu_cancel),
      .ifu_busy       (ifu_busy),
      .ifu_data_valid (ifu_data_valid),
      .lsu_data_valid (lsu_data_valid),
      .rdata          (rdata)
   );

   biu_axi_ctrl u_axi_ctrl (
      .clk        (clk),
      .reset      (reset),
      .rd_pending (rd_pending),
      .rd_beat    (rd_beat),
      .rd_free    (rd_free),
      .rd_issued  (rd_issued),
      .ifu_busy   (ifu_busy),
      .ar_ready   (ar_ready),
      .ar_valid   (ar_valid),
      .ar_beat    (ar_beat),
      .r_valid    (r_valid),
      .r_beat     (r_beat),
      .r_ready    (r_ready),
      .r_fire     (r_fire),
      .burst_done (burst_done),
      .wr_beat    (wr_beat),
      .w_beat     (buf_w_beat),
      .fill_en    (fill_en),
      .w_pop      (w_pop),
      .aw_ready   (aw_ready),
      .aw_valid   (aw_valid),
      .aw_beat    (aw_beat),
      .w_ready    (w_ready),
      .w_valid    (w_valid),
      .w_out      (w_beat),
      .b_valid    (b_valid),
      .b_beat     (b_beat),
      .b_ready    (b_ready)
   );

   // Both requesters share the one read data register
   assign ifu_data = rdata;
   assign lsu_data = rdata;

endmodule

/* testbench/tb_clock.sv */
module tb_clock (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Reset held for three rising edges
   initial begin
      reset = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
   end

endmodule

/* testbench/tb_biu.sv */
`include "biu_settings.svh"

module tb_biu;

   localparam int NUM_TESTS       = 6;
   localparam int TEST_MAX_CYCLES = 600;
   localparam int TIMEOUT_CYCLES  = NUM_TESTS * TEST_MAX_CYCLES + 400;
   localparam int MEM_WORDS       = 256;

   logic            clk;
   logic            reset;

   logic            ifu_rd_req;
   biu_pkg::addr_t  ifu_rd_addr;
   logic            ifu_cancel;
   logic            ifu_rd_ack;
   logic            ifu_data_valid;
   biu_pkg::data_t  ifu_data;
   logic            lsu_rd_req;
   biu_pkg::addr_t  lsu_rd_addr;
   logic            lsu_rd_ack;
   logic            lsu_data_valid;
   biu_pkg::data_t  lsu_data;
   logic            lsu_wr_req;
   biu_pkg::addr_t  lsu_wr_addr;
   biu_pkg::data_t  lsu_wr_data;
   biu_pkg::strb_t  lsu_wr_strb;
   logic            lsu_wr_last;
   logic            lsu_wr_ack;

   logic            ar_valid;
   logic            ar_ready;
   biu_pkg::axi_a_t ar_beat;
   logic            r_valid;
   logic            r_ready;
   biu_pkg::axi_r_t r_beat;
   logic            aw_valid;
   logic            aw_ready;
   biu_pkg::axi_a_t aw_beat;
   logic            w_valid;
   logic            w_ready;
   biu_pkg::axi_w_t w_beat;
   logic            b_valid;
   logic            b_ready;
   biu_pkg::axi_b_t b_beat;

   integer          seed = 32'heee1eebf;

   // Memory model contents and the expected image kept by the tests
   biu_pkg::data_t  mem     [MEM_WORDS];
   biu_pkg::data_t  exp_mem [MEM_WORDS];
   biu_pkg::axi_a_t ar_log [$];
   biu_pkg::axi_a_t aw_log [$];
   biu_pkg::data_t  ifu_q [$];
   biu_pkg::data_t  lsu_q [$];
   biu_pkg::axi_a_t rd_cmd;
   biu_pkg::axi_a_t wr_cmd;
   logic            bp_on;
   logic            rd_busy;
   logic            b_due;
   logic            r_fired;
   logic            b_fired;
   logic [7:0]      w_idx;
   int              rd_cnt;
   int              wr_cnt;
   int              b_count;
   logic            exp_last_ifu;

   tb_clock u_clock (
      .clk   (clk),
      .reset (reset)
   );

   biu_top i_dut (.*);

   task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string msg);
      if (got !== exp) begin
         $display("Fail at time %0t: %s, got %0h expected %0h", $time, msg, got, exp);
         $display("TEST FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic logic [7:0] word_index(input biu_pkg::addr_t a);
      return a[9:2];
   endfunction

   function automatic biu_pkg::data_t fill_word(input biu_pkg::addr_t a);
      return (a * 32'h0101_0193) ^ 32'h5a5a_a5a5;
   endfunction

   function automatic biu_pkg::data_t merge_bytes(input biu_pkg::data_t old,
                                                  input biu_pkg::data_t data,
                                                  input biu_pkg::strb_t strb);
      biu_pkg::data_t res;
      res = old;
      for (int b = 0; b < `BIU_DATA_W / 8; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = data[8*b +: 8];
         end
      end
      return res;
   endfunction

   // Half the cycles stall when back-pressure is on
   function automatic logic ready_draw();
      int r;
      r = $random(seed);
      return !bp_on || r[0];
   endfunction

   // AXI memory model samples handshakes mid-cycle and drives after the edge
   always begin
      @(negedge clk);
      r_fired = 1'b0;
      b_fired = 1'b0;
      if (reset === 1'b0) begin
         r_fired = r_valid && r_ready;
         b_fired = b_valid && b_ready;
         if (ar_valid && ar_ready) begin
            rd_cmd  = ar_beat;
            rd_cnt  = 0;
            rd_busy = 1'b1;
            ar_log.push_back(ar_beat);
         end
         if (r_fired) begin
            if (rd_cnt == int'(rd_cmd.len)) begin
               rd_busy = 1'b0;
            end
            rd_cnt++;
         end
         if (aw_valid && aw_ready) begin
            wr_cmd = aw_beat;
            wr_cnt = 0;
            aw_log.push_back(aw_beat);
         end
         if (w_valid && w_ready) begin
            w_idx      = word_index(wr_cmd.addr + biu_pkg::addr_t'(4 * wr_cnt));
            mem[w_idx] = merge_bytes(mem[w_idx], w_beat.data, w_beat.strb);
            check_eq(w_beat.last, wr_cnt == int'(wr_cmd.len), "W last on final beat");
            if (w_beat.last) begin
               b_due = 1'b1;
            end
            wr_cnt++;
         end
         if (b_fired) begin
            b_count++;
         end
      end
      @(posedge clk);
      #1;
      ar_ready = ready_draw();
      aw_ready = ready_draw();
      w_ready  = ready_draw();
      if (r_fired || !r_valid) begin
         r_valid     = rd_busy && ready_draw();
         r_beat.id   = rd_cmd.id;
         r_beat.data = mem[word_index(rd_cmd.addr + biu_pkg::addr_t'(4 * rd_cnt))];
         r_beat.resp = 2'b00;
         r_beat.last = rd_cnt == int'(rd_cmd.len);
      end
      if (b_fired || !b_valid) begin
         b_valid = b_due && ready_draw();
         if (b_valid) begin
            b_due = 1'b0;
         end
         b_beat.id   = wr_cmd.id;
         b_beat.resp = 2'b00;
      end
   end

   always @(negedge clk) begin
      if (reset === 1'b0) begin
         if (ifu_data_valid) begin
            ifu_q.push_back(ifu_data);
         end
         if (lsu_data_valid) begin
            lsu_q.push_back(lsu_data);
         end
      end
   end

   task automatic issue_read(input logic is_ifu, input biu_pkg::addr_t addr);
      if (is_ifu) begin
         ifu_rd_req  = 1'b1;
         ifu_rd_addr = addr;
      end else begin
         lsu_rd_req  = 1'b1;
         lsu_rd_addr = addr;
      end
      do begin
         @(posedge clk);
         #1;
      end while (!(is_ifu ? ifu_rd_ack : lsu_rd_ack));
      ifu_rd_req   = 1'b0;
      lsu_rd_req   = 1'b0;
      exp_last_ifu = is_ifu;
   endtask

   task automatic read_expect(input logic is_ifu, input biu_pkg::addr_t addr);
      int              beats;
      biu_pkg::data_t  got;
      biu_pkg::axi_a_t a;
      beats = is_ifu ? `BIU_IFU_BEATS : 1;
      for (int k = 0; k < beats; k++) begin
         while ((is_ifu ? ifu_q.size() : lsu_q.size()) == 0) begin
            @(posedge clk);
            #1;
         end
         got = is_ifu ? ifu_q.pop_front() : lsu_q.pop_front();
         check_eq(got, exp_mem[word_index(addr + biu_pkg::addr_t'(4 * k))],
                  is_ifu ? "IFU read data" : "LSU read data");
      end
      check_eq(ar_log.size() > 0, 1'b1, "AR beat issued for the read");
      a = ar_log.pop_front();
      check_eq(a.id, is_ifu ? `BIU_IFU_ID : `BIU_LSU_ID, "AR id");
      check_eq(a.len, is_ifu ? `BIU_IFU_BEATS - 1 : 0, "AR len");
      check_eq(a.addr, addr, "AR address");
   endtask

   task automatic read_and_check(input logic is_ifu, input biu_pkg::addr_t addr);
      issue_read(is_ifu, addr);
      read_expect(is_ifu, addr);
   endtask

   // Both request in the same cycle; the one not granted last must win
   task automatic read_tie(input biu_pkg::addr_t ifu_addr, input biu_pkg::addr_t lsu_addr);
      logic ifu_first;
      logic ifu_done;
      logic lsu_done;
      logic first_seen;
      ifu_first   = !exp_last_ifu;
      ifu_done    = 1'b0;
      lsu_done    = 1'b0;
      first_seen  = 1'b0;
      ifu_rd_req  = 1'b1;
      ifu_rd_addr = ifu_addr;
      lsu_rd_req  = 1'b1;
      lsu_rd_addr = lsu_addr;
      while (!(ifu_done && lsu_done)) begin
         @(posedge clk);
         #1;
         if (ifu_rd_ack || lsu_rd_ack) begin
            if (!first_seen) begin
               check_eq(ifu_rd_ack, ifu_first, "IFU wins the tie");
               first_seen = 1'b1;
            end
            if (ifu_rd_ack) begin
               ifu_rd_req = 1'b0;
               ifu_done   = 1'b1;
            end
            if (lsu_rd_ack) begin
               lsu_rd_req = 1'b0;
               lsu_done   = 1'b1;
            end
            exp_last_ifu = ifu_rd_ack;
         end
      end
      if (ifu_first) begin
         read_expect(1'b1, ifu_addr);
         read_expect(1'b0, lsu_addr);
      end else begin
         read_expect(1'b0, lsu_addr);
         read_expect(1'b1, ifu_addr);
      end
   endtask

   task automatic lsu_write(input biu_pkg::addr_t addr, input int n);
      biu_pkg::data_t  d;
      biu_pkg::strb_t  s;
      biu_pkg::axi_a_t a;
      logic [7:0]      idx;
      int              b_before;
      b_before = b_count;
      for (int i = 0; i < n; i++) begin
         d            = $random(seed);
         s            = $random(seed);
         lsu_wr_req   = 1'b1;
         lsu_wr_addr  = addr;
         lsu_wr_data  = d;
         lsu_wr_strb  = s;
         lsu_wr_last  = i == n - 1;
         idx          = word_index(addr + biu_pkg::addr_t'(4 * i));
         exp_mem[idx] = merge_bytes(exp_mem[idx], d, s);
         do begin
            @(negedge clk);
         end while (!lsu_wr_ack);
         @(posedge clk);
         #1;
      end
      lsu_wr_req  = 1'b0;
      lsu_wr_last = 1'b0;
      while (b_count == b_before) begin
         @(posedge clk);
         #1;
      end
      a = aw_log.pop_front();
      check_eq(a.id, `BIU_LSU_ID, "AW id");
      check_eq(a.len, n - 1, "AW len");
      check_eq(a.addr, addr, "AW address");
   endtask

   task automatic write_then_read_back(input biu_pkg::addr_t addr, input int n);
      lsu_write(addr, n);
      for (int k = 0; k < n; k++) begin
         read_and_check(1'b0, addr + biu_pkg::addr_t'(4 * k));
      end
   endtask

   task automatic arbitration_rounds();
      read_tie(32'h0000_0100, 32'h0000_0204);
      issue_read(1'b1, 32'h0000_0140);
      read_expect(1'b1, 32'h0000_0140);
      // IFU granted last, so the LSU takes this one
      read_tie(32'h0000_0180, 32'h0000_0208);
   endtask

   task automatic single_lsu_reads();
      read_and_check(1'b0, 32'h0000_0010);
      read_and_check(1'b0, 32'h0000_0014);
      read_and_check(1'b0, 32'h0000_03fc);
   endtask

   task automatic ifu_line_fills();
      read_and_check(1'b1, 32'h0000_0200);
      read_and_check(1'b1, 32'h0000_03f0);
   endtask

   task automatic strobed_write_bursts();
      for (int n = 1; n <= `BIU_WR_DEPTH; n++) begin
         write_then_read_back(biu_pkg::addr_t'(32'h40 * n), n);
      end
      read_and_check(1'b1, 32'h0000_00c0);
   endtask

   task automatic cancelled_line_fill();
      biu_pkg::axi_a_t a;
      int              kept;
      issue_read(1'b1, 32'h0000_0300);
      while (ifu_q.size() == 0) begin
         @(posedge clk);
         #1;
      end
      ifu_cancel = 1'b1;
      @(posedge clk);
      #1;
      ifu_cancel = 1'b0;
      // Beats accepted before the cancel are already in the queue
      kept = ifu_q.size();
      // Remaining beats still drain from the bus
      while (rd_busy) begin
         @(posedge clk);
         #1;
      end
      repeat (2) @(posedge clk);
      #1;
      check_eq(ifu_q.size(), kept, "no IFU data after cancel");
      check_eq(kept < `BIU_IFU_BEATS, 1'b1, "cancel drops the rest of the fill");
      for (int k = 0; k < kept; k++) begin
         check_eq(ifu_q.pop_front(), exp_mem[word_index(32'h300 + 4 * k)],
                  "IFU data before cancel");
      end
      a = ar_log.pop_front();
      check_eq(a.len, `BIU_IFU_BEATS - 1, "AR len of cancelled fill");
      read_and_check(1'b0, 32'h0000_0304);
      read_and_check(1'b1, 32'h0000_0300);
   endtask

   task automatic random_backpressure();
      bp_on = 1'b1;
      read_and_check(1'b0, 32'h0000_0020);
      read_and_check(1'b1, 32'h0000_0240);
      read_tie(32'h0000_0280, 32'h0000_0024);
      for (int n = 1; n <= `BIU_WR_DEPTH; n++) begin
         write_then_read_back(biu_pkg::addr_t'(32'h300 + 32'h10 * n), n);
      end
      read_and_check(1'b1, 32'h0000_0320);
      // Write and read in flight together
      fork
         lsu_write(32'h0000_03c0, 3);
         read_and_check(1'b1, 32'h0000_02c0);
      join
      for (int k = 0; k < 3; k++) begin
         read_and_check(1'b0, biu_pkg::addr_t'(32'h3c0 + 4 * k));
      end
      bp_on = 1'b0;
   endtask

   initial begin
      ifu_rd_req   = 1'b0;
      ifu_rd_addr  = '0;
      ifu_cancel   = 1'b0;
      lsu_rd_req   = 1'b0;
      lsu_rd_addr  = '0;
      lsu_wr_req   = 1'b0;
      lsu_wr_addr  = '0;
      lsu_wr_data  = '0;
      lsu_wr_strb  = '0;
      lsu_wr_last  = 1'b0;
      ar_ready     = 1'b0;
      r_valid      = 1'b0;
      r_beat       = '0;
      aw_ready     = 1'b0;
      w_ready      = 1'b0;
      b_valid      = 1'b0;
      b_beat       = '0;
      bp_on        = 1'b0;
      rd_busy      = 1'b0;
      b_due        = 1'b0;
      rd_cnt       = 0;
      wr_cnt       = 0;
      b_count      = 0;
      rd_cmd       = '0;
      wr_cmd       = '0;
      exp_last_ifu = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i]     = fill_word(biu_pkg::addr_t'(4 * i));
         exp_mem[i] = mem[i];
      end
      wait (reset === 1'b0);
      @(posedge clk);
      #1;
      // Runs first so the reset grant order is seen
      arbitration_rounds();
      single_lsu_reads();
      ifu_line_fills();
      strobed_write_bursts();
      cancelled_line_fill();
      random_backpressure();
      check_eq(ifu_q.size() + lsu_q.size(), 0, "no stray read data");
      $display("TEST PASS");
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule

/* verilog.f */
+incdir+rtl
rtl/biu_pkg.sv
rtl/biu_rd_arb.sv
rtl/biu_wr_buf.sv
rtl/biu_rdata_route.sv
rtl/biu_axi_ctrl.sv
rtl/biu_top.sv
testbench/tb_clock.sv
testbench/tb_biu.sv
